// File: Bender.yml
package:
  name: simple_axi_write

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/simple_wr_pkg.sv
      - verilog/axi_wr_pkg.sv
      - verilog/simple_word_taker.sv
      - verilog/write_data_fifo.sv
      - verilog/burst_planner.sv
      - verilog/axi_write_engine.sv
      - verilog/simple_axi_write_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_simple_axi_write.sv

// File: list.f
+incdir+verilog
verilog/simple_wr_pkg.sv
verilog/axi_wr_pkg.sv
verilog/simple_word_taker.sv
verilog/write_data_fifo.sv
verilog/burst_planner.sv
verilog/axi_write_engine.sv
verilog/simple_axi_write_top.sv
tb/tb_clk_gen.sv
tb/tb_simple_axi_write.sv

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock and power-on reset
module tb_clk_gen #(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 8
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1 rst_o = 1'b0; // Released together with the other stimulus
   end

endmodule

`default_nettype wire

// File: tb/tb_simple_axi_write.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_cfg.svh"

module tb_simple_axi_write;

   import simple_wr_pkg::*;
   import axi_wr_pkg::*;

   localparam int CLK_PERIOD      = 10;
   localparam int TOTAL_WORDS     = 126; // Sum of all request lengths below
   localparam int WATCHDOG_CYCLES = 200 * TOTAL_WORDS + 2000;
   localparam int BYTES           = `BRIDGE_DATA_W / 8;

   typedef logic [`BRIDGE_ADDR_W-1:0] addr_t;
   typedef logic [`BRIDGE_DATA_W-1:0] word_t;

   logic        clk;
   logic        rst;
   logic        m_wvalid;
   simple_req_t m_req;
   word_t       m_wdata;
   logic        m_wready;
   logic        m_wlast;
   axi_aw_t     aw;
   logic        awvalid;
   logic        awready;
   axi_w_t      w;
   logic        wvalid;
   logic        wready;
   axi_resp_e   bresp;
   logic        bvalid;
   logic        done;
   logic        resp_err;

   logic        stall_en;
   int          err_burst;  // Index of the B that gets SLVERR or -1 for none
   addr_t       wr_addr;
   int          beat;
   int          b_count;
   int          done_count;
   axi_aw_t     aw_log[$];
   axi_aw_t     exp_aw[$];
   word_t       exp_data[$];
   word_t       mem[addr_t]; // Sparse slave memory by byte address

   tb_clk_gen u_clk (.clk_o(clk), .rst_o(rst));

   simple_axi_write_top uut (
      .clk_i         (clk),
      .rst_i         (rst),
      .m_wvalid_i    (m_wvalid),
      .m_req_i       (m_req),
      .m_wdata_i     (m_wdata),
      .m_wready_o    (m_wready),
      .m_wlast_o     (m_wlast),
      .axi_aw_o      (aw),
      .axi_awvalid_o (awvalid),
      .axi_awready_i (awready),
      .axi_w_o       (w),
      .axi_wvalid_o  (wvalid),
      .axi_wready_i  (wready),
      .axi_bresp_i   (bresp),
      .axi_bvalid_i  (bvalid),
      .done_o        (done),
      .resp_err_o    (resp_err)
   );

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1);
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         report_failure($sformatf("ERROR %s: expected %h, got %h", name, exp, got));
   endtask

   task automatic compare_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
      if (got !== exp)
         report_failure($sformatf("ERROR %s: expected %h, got %h", name, exp, got));
   endtask

   task automatic compare_aw(input string name, input axi_aw_t got, input axi_aw_t exp);
      if (got !== exp)
         report_failure({$sformatf("ERROR %s: expected addr %h len %h size %h burst %h", name,
                                   exp.awaddr, exp.awlen, exp.awsize, exp.awburst),
                         $sformatf(", got addr %h len %h size %h burst %h",
                                   got.awaddr, got.awlen, got.awsize, got.awburst)});
   endtask

   task automatic compare_word(input addr_t addr, input word_t exp);
      if (!mem.exists(addr))
         report_failure($sformatf("Slave memory was never written at address %h", addr));
      else if (mem[addr] !== exp)
         report_failure($sformatf("ERROR mem[%h]: expected %h, got %h", addr, exp, mem[addr]));
   endtask

   // AXI slave model samples handshakes at the edge and drives 1 ns later
   always @(posedge clk) begin : slave_model
      logic b_due;
      b_due = 1'b0;
      if (awvalid && awready) begin
         aw_log.push_back(aw);
         wr_addr = aw.awaddr;
         beat    = 0;
      end
      if (wvalid && wready) begin
         compare_bit("wstrb all ones", &w.wstrb, 1'b1);
         compare_bit("wlast", w.wlast, beat == int'(exp_aw[aw_log.size() - 1].awlen));
         mem[wr_addr] = w.wdata;
         wr_addr += addr_t'(BYTES);
         beat++;
         b_due = w.wlast;
      end
      if (bvalid)
         b_count++; // bready is always high
      if (done)
         done_count++;
      #1;
      awready = stall_en ? ($urandom_range(3) != 0) : 1'b1;
      wready  = stall_en ? ($urandom_range(3) != 0) : 1'b1;
      bvalid  = b_due;
      bresp   = (b_due && b_count == err_burst) ? RESP_SLVERR : RESP_OKAY;
   end

   // Expected AW stream from the splitting rule
   task automatic plan_bursts(input addr_t addr, input int len);
      axi_aw_t cmd;
      int      rem;
      int      room;
      int      n;
      exp_aw.delete();
      rem = len;
      while (rem > 0) begin
         room = (`BRIDGE_BOUNDARY - int'(addr % `BRIDGE_BOUNDARY)) / BYTES;
         n = rem;
         if (n > `BRIDGE_MAX_BEATS)
            n = `BRIDGE_MAX_BEATS;
         if (n > room)
            n = room;
         cmd.awaddr  = addr;
         cmd.awlen   = 8'(n - 1);
         cmd.awsize  = 3'd2; // 4 bytes per beat
         cmd.awburst = BURST_INCR;
         exp_aw.push_back(cmd);
         addr += addr_t'(n * BYTES);
         rem  -= n;
      end
   endtask

   task automatic make_words(input word_t base, input int len, input bit random);
      exp_data.delete();
      for (int i = 0; i < len; i++)
         exp_data.push_back(random ? word_t'($urandom) : base + word_t'(i));
   endtask

   // Sends one request, waits for done_o and checks AW log, data and status
   task automatic run_request(input addr_t addr, input int len, input logic expect_err);
      int   idx;
      int   wait_cycles;
      logic seen_done;
      idx         = 0;
      wait_cycles = 0;
      seen_done   = 1'b0;
      aw_log.delete();
      mem.delete();
      b_count    = 0;
      done_count = 0;
      plan_bursts(addr, len);
      m_wvalid   = 1'b1;
      m_req.addr = addr;
      m_req.len  = `BRIDGE_LEN_W'(len);
      m_wdata    = exp_data[0];
      while (idx < len) begin
         @(posedge clk);
         if (m_wready) begin
            compare_bit("m_wlast_o", m_wlast, idx == len - 1);
            idx++;
         end
         #1;
         if (idx < len)
            m_wdata = exp_data[idx];
         else
            m_wvalid = 1'b0;
      end
      while (!seen_done) begin
         @(posedge clk);
         if (done) begin
            seen_done = 1'b1;
            compare_resp("resp_err_o", resp_err ? RESP_SLVERR : RESP_OKAY,
                         expect_err ? RESP_SLVERR : RESP_OKAY);
            if (b_count != exp_aw.size())
               report_failure("done_o was raised before every B response came back");
         end else if (wait_cycles > 200 * len + 100) begin
            report_failure("done_o never came after the request was sent");
         end
         wait_cycles++;
      end
      repeat (3) @(posedge clk);
      #1;
      if (done_count != 1)
         report_failure($sformatf("done_o pulsed %0d times for one request", done_count));
      if (aw_log.size() != exp_aw.size())
         report_failure($sformatf("Saw %0d bursts where %0d were expected",
                                  aw_log.size(), exp_aw.size()));
      foreach (exp_aw[i])
         compare_aw($sformatf("AW %0d", i), aw_log[i], exp_aw[i]);
      if (mem.num() != len)
         report_failure($sformatf("Slave saw %0d written words instead of %0d", mem.num(), len));
      for (int i = 0; i < len; i++)
         compare_word(addr + addr_t'(i * BYTES), exp_data[i]);
   endtask

   task automatic single_burst_write();
      make_words(32'hA000_0000, 4, 1'b0);
      run_request(32'h0000_1000, 4, 1'b0);
   endtask

   task automatic long_request_split();
      make_words(32'hB000_0000, 40, 1'b0);
      run_request(32'h0000_2000, 40, 1'b0); // 16 + 16 + 8
   endtask

   task automatic boundary_crossing_write();
      make_words(32'hC000_0000, 10, 1'b0);
      run_request(32'h0000_2FF4, 10, 1'b0); // 3 words then 7 from 0x3000
   endtask

   task automatic stalled_slave_write();
      stall_en = 1'b1;
      make_words('0, 25, 1'b1);
      run_request(32'h0001_0040, 25, 1'b0);
      stall_en = 1'b0;
   endtask

   task automatic single_word_write();
      make_words(32'hD000_0000, 1, 1'b0);
      run_request(32'h0000_4000, 1, 1'b0);
   endtask

   task automatic slave_error_recovery();
      err_burst = 1; // Middle burst of three
      make_words(32'hE000_0000, 40, 1'b0);
      run_request(32'h0000_5000, 40, 1'b1);
      err_burst = -1;
      make_words(32'hF000_0000, 6, 1'b0);
      run_request(32'h0000_6000, 6, 1'b0); // Flag must clear again
   endtask

   initial begin
      void'($urandom(32'h7e47));
      m_wvalid  = 1'b0;
      m_req     = '0;
      m_wdata   = '0;
      awready   = 1'b0;
      wready    = 1'b0;
      bvalid    = 1'b0;
      bresp     = RESP_OKAY;
      stall_en  = 1'b0;
      err_burst = -1;
      @(negedge rst);
      compare_bit("m_wready_o", m_wready, 1'b0);
      compare_bit("axi_awvalid_o", awvalid, 1'b0);
      compare_bit("axi_wvalid_o", wvalid, 1'b0);
      compare_bit("done_o", done, 1'b0);
      single_burst_write();
      long_request_split();
      boundary_crossing_write();
      stalled_slave_write();
      single_word_write();
      slave_error_recovery();
      $display("** PASS **");
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired before the tests finished");
      $display("** FAIL **");
      $fatal(1);
   end

endmodule

`default_nettype wire

// File: verilog/axi_bridge_cfg.svh
`ifndef AXI_BRIDGE_CFG_SVH
`define AXI_BRIDGE_CFG_SVH

// Bus widths
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32
`define BRIDGE_LEN_W 16 // Request length in words

// Burst shaping
`define BRIDGE_MAX_BEATS 16
`define BRIDGE_BOUNDARY 4096 // Bytes, no burst may cross it

`define BRIDGE_FIFO_DEPTH 8

`endif

// File: verilog/axi_wr_pkg.sv
`default_nettype none

`include "axi_bridge_cfg.svh"

package axi_wr_pkg;

   typedef enum logic [1:0] {
      BURST_FIXED = 2'b00,
      BURST_INCR  = 2'b01,
      BURST_WRAP  = 2'b10
   } axi_burst_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_EXOKAY = 2'b01,
      RESP_SLVERR = 2'b10,
      RESP_DECERR = 2'b11
   } axi_resp_e;

   typedef struct packed {
      logic [`BRIDGE_ADDR_W-1:0] awaddr;
      logic [7:0]                awlen;
      logic [2:0]                awsize;
      axi_burst_e                awburst;
   } axi_aw_t;

   typedef struct packed {
      logic [`BRIDGE_DATA_W-1:0]   wdata;
      logic [`BRIDGE_DATA_W/8-1:0] wstrb;
      logic                        wlast;
   } axi_w_t;

   typedef enum logic [1:0] {ENG_IDLE, ENG_ADDR, ENG_DATA, ENG_RESP} engine_state_e;

endpackage

`default_nettype wire

// File: verilog/axi_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_cfg.svh"

// Runs one burst at a time on the AXI write channels in the order AW, W and B
module axi_write_engine (
   input  logic                      clk_i,
   input  logic                      rst_i,

   input  simple_wr_pkg::burst_cmd_t cmd_i,
   input  logic                      cmd_valid_i,
   output logic                      cmd_take_o,

   input  logic [`BRIDGE_DATA_W-1:0] fifo_data_i,
   input  logic                      fifo_empty_i,
   output logic                      fifo_pop_o,

   output axi_wr_pkg::axi_aw_t       axi_aw_o,
   output logic                      axi_awvalid_o,
   input  logic                      axi_awready_i,
   output axi_wr_pkg::axi_w_t        axi_w_o,
   output logic                      axi_wvalid_o,
   input  logic                      axi_wready_i,
   input  axi_wr_pkg::axi_resp_e     axi_bresp_i,
   input  logic                      axi_bvalid_i,

   output logic                      done_o,
   output logic                      resp_err_o
);

   import axi_wr_pkg::*;

   localparam logic [2:0] AXI_SIZE = 3'($clog2(`BRIDGE_DATA_W/8));

   engine_state_e state_q;

   axi_aw_t    aw_q;
   logic       awvalid_q;
   logic [7:0] beat_q;     // Beats sent in this burst
   logic       last_q;     // Burst is the final one of the request
   logic       first_q;    // Next take opens a new request
   logic       done_q;
   logic       resp_err_q;
   logic       b_fire;

   assign b_fire = axi_bvalid_i && (state_q == ENG_RESP); // bready is tied high

   assign cmd_take_o    = (state_q == ENG_IDLE) && cmd_valid_i;
   assign axi_aw_o      = aw_q;
   assign axi_awvalid_o = awvalid_q;
   assign axi_wvalid_o  = (state_q == ENG_DATA) && !fifo_empty_i;
   assign fifo_pop_o    = axi_wvalid_o && axi_wready_i;
   assign done_o        = done_q;
   assign resp_err_o    = resp_err_q;

   always_comb begin
      axi_w_o.wdata = fifo_data_i;
      axi_w_o.wstrb = '1; // Whole words only
      axi_w_o.wlast = (beat_q == aw_q.awlen);
   end

   always_ff @(posedge clk_i) begin
      if (cmd_take_o) begin
         aw_q.awaddr  <= cmd_i.addr;
         aw_q.awlen   <= cmd_i.len;
         aw_q.awsize  <= AXI_SIZE;
         aw_q.awburst <= BURST_INCR;
         last_q       <= cmd_i.last;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q    <= ENG_IDLE;
         awvalid_q  <= 1'b0;
         beat_q     <= '0;
         first_q    <= 1'b1;
         done_q     <= 1'b0;
         resp_err_q <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            ENG_IDLE:
               if (cmd_take_o) begin
                  awvalid_q <= 1'b1;
                  beat_q    <= '0;
                  state_q   <= ENG_ADDR;
                  if (first_q) begin
                     first_q    <= 1'b0;
                     resp_err_q <= 1'b0;
                  end
               end
            ENG_ADDR:
               if (axi_awready_i) begin
                  awvalid_q <= 1'b0;
                  state_q   <= ENG_DATA;
               end
            ENG_DATA:
               if (fifo_pop_o) begin
                  beat_q <= beat_q + 8'd1;
                  if (axi_w_o.wlast)
                     state_q <= ENG_RESP;
               end
            ENG_RESP:
               if (b_fire) begin
                  if (axi_bresp_i != RESP_OKAY)
                     resp_err_q <= 1'b1; // Sticky for the rest of the request
                  if (last_q) begin
                     done_q  <= 1'b1;
                     first_q <= 1'b1;
                  end
                  state_q <= ENG_IDLE;
               end
            default:
               state_q <= ENG_IDLE;
         endcase
      end
   end

   aw_stable_while_stalled: assert property (@(posedge clk_i) disable iff (rst_i)
      (axi_awvalid_o && !axi_awready_i) |=> (axi_awvalid_o && $stable(axi_aw_o)));

endmodule

`default_nettype wire

// File: verilog/burst_planner.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_cfg.svh"

// Cuts one client request into INCR bursts that stay within the beat limit
// and never cross the address boundary
module burst_planner (
   input  logic                       clk_i,
   input  logic                       rst_i,

   input  logic                       start_i,
   input  simple_wr_pkg::simple_req_t req_i,

   output simple_wr_pkg::burst_cmd_t  cmd_o,
   output logic                       cmd_valid_o,
   input  logic                       cmd_take_i
);

   import simple_wr_pkg::*;

   localparam int BND_W  = $clog2(`BRIDGE_BOUNDARY);
   localparam int BYTE_W = $clog2(`BRIDGE_DATA_W/8);

   planner_state_e state_q;

   logic [`BRIDGE_ADDR_W-1:0] addr_q; // Start of the next burst
   logic [`BRIDGE_LEN_W-1:0]  rem_q;  // Words not yet planned

   logic [BND_W:0]            bnd_words;
   logic [`BRIDGE_LEN_W-1:0]  beats;

   always_comb begin
      // Words left before the next boundary
      bnd_words = ((BND_W+1)'(`BRIDGE_BOUNDARY) - {1'b0, addr_q[BND_W-1:0]}) >> BYTE_W;

      beats = rem_q;
      if (beats > `BRIDGE_LEN_W'(`BRIDGE_MAX_BEATS))
         beats = `BRIDGE_LEN_W'(`BRIDGE_MAX_BEATS);
      if (beats > `BRIDGE_LEN_W'(bnd_words))
         beats = `BRIDGE_LEN_W'(bnd_words);
   end

   assign cmd_o.addr  = addr_q;
   assign cmd_o.len   = 8'(beats - `BRIDGE_LEN_W'(1));
   assign cmd_o.last  = (beats == rem_q);
   assign cmd_valid_o = (state_q != PL_IDLE);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= PL_IDLE;
      end else begin
         case (state_q)
            PL_IDLE:
               if (start_i)
                  state_q <= PL_PLAN;
            PL_PLAN, PL_WAIT_TAKE:
               if (cmd_take_i)
                  state_q <= cmd_o.last ? PL_IDLE : PL_PLAN;
               else
                  state_q <= PL_WAIT_TAKE; // Engine still busy with the previous burst
            default:
               state_q <= PL_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == PL_IDLE && start_i) begin
         addr_q <= req_i.addr;
         rem_q  <= req_i.len;
      end else if (cmd_valid_o && cmd_take_i) begin
         addr_q <= addr_q + (`BRIDGE_ADDR_W'(beats) << BYTE_W);
         rem_q  <= rem_q - beats;
      end
   end

   // A presented command may not change until it is taken
   cmd_held_until_take: assert property (@(posedge clk_i) disable iff (rst_i)
      (cmd_valid_o && !cmd_take_i) |=> (cmd_valid_o && $stable(cmd_o)));

endmodule

`default_nettype wire

// File: verilog/simple_axi_write_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_cfg.svh"

// Simple streaming write port to AXI4 write master
module simple_axi_write_top (
   input  logic                       clk_i,
   input  logic                       rst_i,

   input  logic                       m_wvalid_i,
   input  simple_wr_pkg::simple_req_t m_req_i,
   input  logic [`BRIDGE_DATA_W-1:0]  m_wdata_i,
   output logic                       m_wready_o,
   output logic                       m_wlast_o,

   output axi_wr_pkg::axi_aw_t        axi_aw_o,
   output logic                       axi_awvalid_o,
   input  logic                       axi_awready_i,
   output axi_wr_pkg::axi_w_t         axi_w_o,
   output logic                       axi_wvalid_o,
   input  logic                       axi_wready_i,
   input  axi_wr_pkg::axi_resp_e      axi_bresp_i,
   input  logic                       axi_bvalid_i,

   output logic                       done_o,
   output logic                       resp_err_o
);

   import simple_wr_pkg::*;

   logic                      start;
   logic                      fifo_push;
   logic                      fifo_pop;
   logic                      fifo_full;
   logic                      fifo_empty;
   logic [`BRIDGE_DATA_W-1:0] push_data;
   logic [`BRIDGE_DATA_W-1:0] head_data;
   burst_cmd_t                cmd;
   logic                      cmd_valid;
   logic                      cmd_take;

   simple_word_taker u_taker (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .m_wvalid_i  (m_wvalid_i),
      .m_req_i     (m_req_i),
      .m_wdata_i   (m_wdata_i),
      .m_wready_o  (m_wready_o),
      .m_wlast_o   (m_wlast_o),
      .start_o     (start),
      .fifo_full_i (fifo_full),
      .fifo_push_o (fifo_push),
      .fifo_data_o (push_data)
   );

   write_data_fifo u_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .push_i  (fifo_push),
      .data_i  (push_data),
      .pop_i   (fifo_pop),
      .data_o  (head_data),
      .empty_o (fifo_empty),
      .full_o  (fifo_full)
   );

   burst_planner u_planner (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .start_i     (start),
      .req_i       (m_req_i),
      .cmd_o       (cmd),
      .cmd_valid_o (cmd_valid),
      .cmd_take_i  (cmd_take)
   );

   axi_write_engine u_engine (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .cmd_i         (cmd),
      .cmd_valid_i   (cmd_valid),
      .cmd_take_o    (cmd_take),
      .fifo_data_i   (head_data),
      .fifo_empty_i  (fifo_empty),
      .fifo_pop_o    (fifo_pop),
      .axi_aw_o      (axi_aw_o),
      .axi_awvalid_o (axi_awvalid_o),
      .axi_awready_i (axi_awready_i),
      .axi_w_o       (axi_w_o),
      .axi_wvalid_o  (axi_wvalid_o),
      .axi_wready_i  (axi_wready_i),
      .axi_bresp_i   (axi_bresp_i),
      .axi_bvalid_i  (axi_bvalid_i),
      .done_o        (done_o),
      .resp_err_o    (resp_err_o)
   );

endmodule

`default_nettype wire

// File: verilog/simple_word_taker.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_cfg.svh"

// Accepts the requested number of words from the client and pushes them
// into the data FIFO while holding the client off whenever the FIFO is full
module simple_word_taker (
   input  logic                       clk_i,
   input  logic                       rst_i,

   input  logic                       m_wvalid_i,
   input  simple_wr_pkg::simple_req_t m_req_i,
   input  logic [`BRIDGE_DATA_W-1:0]  m_wdata_i,
   output logic                       m_wready_o,
   output logic                       m_wlast_o,

   output logic                       start_o,

   input  logic                       fifo_full_i,
   output logic                       fifo_push_o,
   output logic [`BRIDGE_DATA_W-1:0]  fifo_data_o
);

   logic                     busy_q;
   logic [`BRIDGE_LEN_W-1:0] count_q; // Words still to accept

   // Capture cycle that ignores zero-length requests
   assign start_o = !busy_q && m_wvalid_i && (m_req_i.len != '0);

   assign m_wready_o  = busy_q && !fifo_full_i;
   assign m_wlast_o   = busy_q && (count_q == `BRIDGE_LEN_W'(1));
   assign fifo_push_o = m_wvalid_i && m_wready_o;
   assign fifo_data_o = m_wdata_i;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         busy_q  <= 1'b0;
         count_q <= '0;
      end else if (start_o) begin
         busy_q  <= 1'b1;
         count_q <= m_req_i.len;
      end else if (fifo_push_o) begin
         count_q <= count_q - `BRIDGE_LEN_W'(1);
         if (m_wlast_o)
            busy_q <= 1'b0; // Ready drops from the next cycle
      end
   end

   // Words remain to be taken for as long as the taker is busy
   count_live_while_busy: assert property (@(posedge clk_i) disable iff (rst_i)
      busy_q |-> (count_q != '0));

   // Nothing more is taken once the final word went in
   ready_drops_after_last: assert property (@(posedge clk_i) disable iff (rst_i)
      (fifo_push_o && m_wlast_o) |=> !m_wready_o);

endmodule

`default_nettype wire

// File: verilog/simple_wr_pkg.sv
`default_nettype none

`include "axi_bridge_cfg.svh"

package simple_wr_pkg;

   // Request as seen on the simple port, held steady on every beat
   typedef struct packed {
      logic [`BRIDGE_ADDR_W-1:0] addr; // Word aligned
      logic [`BRIDGE_LEN_W-1:0]  len;  // In words
   } simple_req_t;

   // One AXI burst worth of work
   typedef struct packed {
      logic [`BRIDGE_ADDR_W-1:0] addr;
      logic [7:0]                len;  // Beats minus one
      logic                      last; // Final burst of the request
   } burst_cmd_t;

   typedef enum logic [1:0] {PL_IDLE, PL_PLAN, PL_WAIT_TAKE} planner_state_e;

endpackage

`default_nettype wire

// File: verilog/write_data_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_cfg.svh"

// Circular buffer of data words between the client side and the W channel
module write_data_fifo (
   input  logic                      clk_i,
   input  logic                      rst_i,

   input  logic                      push_i,
   input  logic [`BRIDGE_DATA_W-1:0] data_i,

   input  logic                      pop_i,
   output logic [`BRIDGE_DATA_W-1:0] data_o, // Head word, valid when not empty

   output logic                      empty_o,
   output logic                      full_o
);

   localparam int DEPTH = `BRIDGE_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);

   logic [`BRIDGE_DATA_W-1:0] mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [PTR_W:0]   count_q; // Needs one more bit to reach DEPTH

   assign data_o  = mem[rd_ptr_q];
   assign empty_o = (count_q == '0);
   assign full_o  = (count_q == (PTR_W+1)'(DEPTH));

   always_ff @(posedge clk_i) begin
      if (push_i)
         mem[wr_ptr_q] <= data_i;
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i)
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
         if (pop_i)
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
         if (push_i && !pop_i)
            count_q <= count_q + 1'b1;
         else if (pop_i && !push_i)
            count_q <= count_q - 1'b1;
      end
   end

   no_pop_when_empty: assert property (@(posedge clk_i) disable iff (rst_i)
      pop_i |-> !empty_o);
   no_push_when_full: assert property (@(posedge clk_i) disable iff (rst_i)
      push_i |-> !full_o);

endmodule

`default_nettype wire
